/* hdl/vidcap_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the BT.656 video capture path
// Bus widths, burst geometry and the structs passed between stages
// Modules pull these in with a wildcard import in their header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vidcap_pkg;

	localparam int mem_depth       = 27;            // Byte address width on memory bus
	localparam int burst_adr_w     = mem_depth - 5; // One burst spans 32 bytes
	localparam int words_per_burst = 8;             // 32-bit pixel words per burst
	localparam int beats_per_burst = 4;             // 64-bit bus beats per burst

	// XY byte of a timing reference code
	typedef struct packed {
		logic       one;  // Always set in a valid code
		logic       f;    // Field
		logic       v;    // Vertical blanking
		logic       h;    // 0 = SAV, 1 = EAV
		logic [3:0] prot; // Protection bits
	} timing_flags_t;

	// Same byte seen raw or split into flags
	typedef union packed {
		logic [7:0]    raw;
		timing_flags_t flags;
	} timing_code_u;

	// One 4:2:2 group of two luma samples sharing chroma
	typedef struct packed {
		logic [7:0] cb;
		logic [7:0] y0;
		logic [7:0] cr;
		logic [7:0] y1;
		logic       field;
		logic       first; // First quad after SAV
	} sample_quad_t;

	// Two RGB565 pixels, pix0 in the low half
	typedef struct packed {
		logic        field;
		logic [15:0] pix1;
		logic [15:0] pix0;
	} pixel_word_t;

	// Memory write request, held until ack
	typedef struct packed {
		logic [mem_depth-1:0] adr;
		logic [63:0]          dat;
		logic                 stb;
	} mem_req_t;

endpackage

/* hdl/bt656_sync_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BT.656 byte stream decoder
// Finds FF 00 00 XY timing codes, tracks field and blanking, and
// emits Cb-Y-Cr-Y quads one cycle after the Y1 byte strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module bt656_sync_decoder import vidcap_pkg::*; (
	input  logic         sys_clk,
	input  logic         sys_rst,
	input  logic [7:0]   vid_data,
	input  logic         vid_stb,
	output sample_quad_t quad,
	output logic         quad_stb
);

	logic [1:0]   pre_cnt;    // Preamble bytes matched so far
	timing_code_u xy;
	logic         xy_ok;
	logic         field_r;
	logic         active;     // Inside active window after SAV
	logic         first_pend; // Next quad is first of the line
	logic [1:0]   phase;      // Cb, Y0, Cr, Y1
	logic [7:0]   cb_r;
	logic [7:0]   y0_r;
	logic [7:0]   cr_r;
	logic         take;

	assign xy.raw = vid_data;

	// Leading one plus protection bits consistent with F, V, H
	assign xy_ok = xy.raw[7] & (xy.flags.prot == {xy.flags.v ^ xy.flags.h,
		xy.flags.f ^ xy.flags.h, xy.flags.f ^ xy.flags.v,
		xy.flags.f ^ xy.flags.v ^ xy.flags.h});

	// FF never occurs in video data, it can only start a preamble
	assign take = vid_stb & active & (pre_cnt == 2'd0) & (vid_data != 8'hff);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pre_cnt    <= 2'd0;
			field_r    <= 1'b0;
			active     <= 1'b0;
			first_pend <= 1'b0;
			phase      <= 2'd0;
			quad_stb   <= 1'b0;
		end else begin
			quad_stb <= 1'b0;
			if (vid_stb) begin
				case (pre_cnt)
					2'd0: if (vid_data == 8'hff) pre_cnt <= 2'd1;
					2'd1, 2'd2: begin
						if (vid_data == 8'h00)
							pre_cnt <= pre_cnt + 2'd1;
						else if (vid_data == 8'hff)
							pre_cnt <= 2'd1; // Restart on repeated FF
						else
							pre_cnt <= 2'd0;
					end
					2'd3: begin // XY byte
						pre_cnt <= 2'd0;
						if (xy_ok) begin
							field_r <= xy.flags.f;
							if (xy.flags.h) begin
								active <= 1'b0; // EAV
							end else begin
								active     <= ~xy.flags.v; // SAV, blanking lines stay closed
								first_pend <= 1'b1;
								phase      <= 2'd0;
							end
						end
					end
				endcase
				if (take) begin
					phase <= phase + 2'd1;
					if (phase == 2'd3) begin
						quad_stb   <= 1'b1;
						first_pend <= 1'b0;
					end
				end
			end
		end
	end

	// Sample gathering
	always_ff @(posedge sys_clk) begin
		if (take) begin
			case (phase)
				2'd0: cb_r <= vid_data;
				2'd1: y0_r <= vid_data;
				2'd2: cr_r <= vid_data;
				2'd3: begin
					quad.cb    <= cb_r;
					quad.y0    <= y0_r;
					quad.cr    <= cr_r;
					quad.y1    <= vid_data;
					quad.field <= field_r;
					quad.first <= first_pend;
				end
			endcase
		end
	end

endmodule

/* hdl/ycbcr_to_rgb565.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YCbCr 4:2:2 quad to RGB565 pixel pair converter
// Two register stages, accepts a new quad every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module ycbcr_to_rgb565 import vidcap_pkg::*; (
	input  logic         sys_clk,
	input  logic         sys_rst,
	input  sample_quad_t quad,
	input  logic         quad_stb,
	output pixel_word_t  pix,
	output logic         pix_stb
);

	logic signed [8:0]  d;      // Cb - 128
	logic signed [8:0]  e;      // Cr - 128
	logic signed [17:0] r_prod;
	logic signed [17:0] g_prod;
	logic signed [17:0] b_prod;
	logic               s1_stb;
	logic               s1_field;
	logic [7:0]         s1_y0;
	logic [7:0]         s1_y1;
	logic signed [9:0]  r_off;
	logic signed [9:0]  g_off;
	logic signed [9:0]  b_off;

	function automatic logic [7:0] clamp8(input logic signed [10:0] s);
		logic [7:0] c;
		if (s < 0)
			c = 8'd0;
		else if (s > 11'sd255)
			c = 8'hff;
		else
			c = s[7:0];
		return c;
	endfunction

	function automatic logic [15:0] to_rgb565(input logic [7:0] y,
		input logic signed [9:0] ro, input logic signed [9:0] go,
		input logic signed [9:0] bo);
		logic signed [10:0] yy;
		logic [7:0]         rc;
		logic [7:0]         gc;
		logic [7:0]         bc;
		yy = $signed({3'b000, y});
		rc = clamp8(yy + 11'(ro));
		gc = clamp8(yy - 11'(go));
		bc = clamp8(yy + 11'(bo));
		return {rc[7:3], gc[7:2], bc[7:3]}; // R high, B low
	endfunction

	assign d = $signed({1'b0, quad.cb}) - 9'sd128;
	assign e = $signed({1'b0, quad.cr}) - 9'sd128;

	assign r_prod = 18'sd359 * 18'(e);
	assign g_prod = 18'sd88 * 18'(d) + 18'sd183 * 18'(e);
	assign b_prod = 18'sd454 * 18'(d);

	// Stage one, offsets are the products >>> 8
	always_ff @(posedge sys_clk) begin
		r_off    <= r_prod[17:8];
		g_off    <= g_prod[17:8];
		b_off    <= b_prod[17:8];
		s1_y0    <= quad.y0;
		s1_y1    <= quad.y1;
		s1_field <= quad.field;
	end

	// Stage two, add to luma, clamp and pack
	always_ff @(posedge sys_clk) begin
		pix.pix0  <= to_rgb565(s1_y0, r_off, g_off, b_off);
		pix.pix1  <= to_rgb565(s1_y1, r_off, g_off, b_off);
		pix.field <= s1_field;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			s1_stb  <= 1'b0;
			pix_stb <= 1'b0;
		end else begin
			s1_stb  <= quad_stb;
			pix_stb <= s1_stb;
		end
	end

endmodule

/* hdl/burst_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst staging memory for the capture DMA
// Written as 32-bit words, read back as registered 64-bit beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module burst_buffer import vidcap_pkg::*; (
	input  logic                                 sys_clk,
	input  logic                                 we,
	input  logic [$clog2(words_per_burst)-1:0]   wa,
	input  logic [31:0]                          wd,
	input  logic [$clog2(beats_per_burst)-1:0]   ra,
	output logic [63:0]                          rd
);

	logic [31:0] mem [words_per_burst];

	always_ff @(posedge sys_clk) begin
		if (we)
			mem[wa] <= wd;
	end

	// Beat k is word 2k+1 above word 2k
	always_ff @(posedge sys_clk) begin
		rd <= {mem[{ra, 1'b1}], mem[{ra, 1'b0}]};
	end

endmodule

/* hdl/capture_dma.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Capture DMA, frame detection and burst writer
// Collects eight pixel words, then writes them as a four-beat burst
// on the strobe/ack memory bus at addresses counted up from adr_base
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module capture_dma import vidcap_pkg::*; (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  logic [1:0]             field_filter,
	input  logic [burst_adr_w-1:0] adr_base,
	input  logic [15:0]            frame_bursts,
	input  pixel_word_t            pix,
	input  logic                   pix_stb,
	output mem_req_t               mem,
	input  logic                   mem_ack,
	output logic                   in_frame,
	output logic                   start_of_frame,
	output logic                   overflow
);

	enum logic [2:0] {
		st_wait_sof,
		st_collect,
		st_request, // Beat 0 goes out in the ack cycle
		st_beat1,
		st_beat2,
		st_beat3
	} state, state_nx;

	logic                   prev_field;
	logic                   prev_valid; // A word has been seen since reset
	logic                   accept;
	logic                   last_word;
	logic                   last_burst;
	logic                   bursting;
	logic [2:0]             wcnt;       // Write slot in burst buffer
	logic [1:0]             beat_ra;    // Read beat, one ahead of the bus
	logic [burst_adr_w-1:0] adr_b;
	logic [15:0]            burst_cnt;
	logic [63:0]            rd;

	burst_buffer u_buf (
		.sys_clk (sys_clk),
		.we      (accept),
		.wa      (wcnt),
		.wd      ({pix.pix1, pix.pix0}),
		.ra      (beat_ra),
		.rd      (rd)
	);

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			prev_valid <= 1'b0;
		else if (pix_stb)
			prev_valid <= 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (pix_stb)
			prev_field <= pix.field;
	end

	assign in_frame = (state != st_wait_sof);

	// Field edge selected by filter, only while idle
	assign start_of_frame = pix_stb & prev_valid & ~in_frame &
		((field_filter[0] & prev_field & ~pix.field) |
		 (field_filter[1] & ~prev_field & pix.field));

	assign accept     = pix_stb & ((state == st_collect) | start_of_frame);
	assign last_word  = accept & (wcnt == 3'(words_per_burst - 1));
	assign bursting   = (state == st_request) | (state == st_beat1) |
		(state == st_beat2) | (state == st_beat3);
	assign last_burst = (burst_cnt + 16'd1) >= frame_bursts; // Zero acts as one

	always_comb begin
		state_nx = state;
		beat_ra  = 2'd0; // Keeps beat 0 ready while waiting for ack
		case (state)
			st_wait_sof: if (start_of_frame) state_nx = st_collect;
			st_collect:  if (last_word) state_nx = st_request;
			st_request: begin
				if (mem_ack) begin
					beat_ra  = 2'd1;
					state_nx = st_beat1;
				end
			end
			st_beat1: begin
				beat_ra  = 2'd2;
				state_nx = st_beat2;
			end
			st_beat2: begin
				beat_ra  = 2'd3;
				state_nx = st_beat3;
			end
			st_beat3: state_nx = last_burst ? st_wait_sof : st_collect;
			default:  state_nx = st_wait_sof;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= st_wait_sof;
			wcnt      <= 3'd0;
			burst_cnt <= 16'd0;
			overflow  <= 1'b0;
		end else begin
			state <= state_nx;
			if (accept)
				wcnt <= wcnt + 3'd1; // Wraps to 0 after word 7
			else if (~in_frame)
				wcnt <= 3'd0;
			if (start_of_frame)
				burst_cnt <= 16'd0;
			else if (state == st_beat3)
				burst_cnt <= burst_cnt + 16'd1;
			if (pix_stb & bursting)
				overflow <= 1'b1; // Sticky until reset
		end
	end

	// Burst address, steps once the last beat is out
	always_ff @(posedge sys_clk) begin
		if (start_of_frame)
			adr_b <= adr_base;
		else if (state == st_beat3)
			adr_b <= adr_b + burst_adr_w'(1);
	end

	assign mem.adr = {adr_b, 5'd0};
	assign mem.dat = rd;
	assign mem.stb = (state == st_request);

endmodule

/* hdl/video_capture_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BT.656 video capture top level
// Decoder, RGB565 converter and capture DMA in a chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_capture_top import vidcap_pkg::*; (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  logic [7:0]             vid_data,
	input  logic                   vid_stb,
	input  logic [1:0]             field_filter,
	input  logic [burst_adr_w-1:0] adr_base,
	input  logic [15:0]            frame_bursts,
	output mem_req_t               mem,
	input  logic                   mem_ack,
	output logic                   in_frame,
	output logic                   start_of_frame,
	output logic                   overflow
);

	sample_quad_t quad;
	logic         quad_stb;
	pixel_word_t  pix;
	logic         pix_stb;

	bt656_sync_decoder u_dec (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.vid_data (vid_data),
		.vid_stb  (vid_stb),
		.quad     (quad),
		.quad_stb (quad_stb)
	);

	ycbcr_to_rgb565 u_conv (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.quad     (quad),
		.quad_stb (quad_stb),
		.pix      (pix),
		.pix_stb  (pix_stb)
	);

	capture_dma u_dma (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.field_filter   (field_filter),
		.adr_base       (adr_base),
		.frame_bursts   (frame_bursts),
		.pix            (pix),
		.pix_stb        (pix_stb),
		.mem            (mem),
		.mem_ack        (mem_ack),
		.in_frame       (in_frame),
		.start_of_frame (start_of_frame),
		.overflow       (overflow)
	);

endmodule

/* test/video_capture_assertions.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory bus and frame control assertions for the capture DMA
// Bound into capture_dma from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module video_capture_assertions import vidcap_pkg::*; (
	input logic     sys_clk,
	input logic     sys_rst,
	input mem_req_t mem,
	input logic     mem_ack,
	input logic     in_frame,
	input logic     start_of_frame
);

	int fail_count = 0; // Assertion failures so far

	// Request held with a stable address until ack
	a_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem.stb && !mem_ack |=> mem.stb && $stable(mem.adr))
		else begin
			fail_count++;
			$error("strobe or address changed before ack");
		end

	// Three beat cycles follow every ack
	a_ack_gap: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem.stb |-> !$past(mem_ack, 1) && !$past(mem_ack, 2) && !$past(mem_ack, 3))
		else begin
			fail_count++;
			$error("new strobe within three cycles of ack");
		end

	a_ack_with_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_ack |-> mem.stb)
		else begin
			fail_count++;
			$error("ack without strobe");
		end

	// Frame closes only in the cycle after the last beat
	a_frame_end: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$fell(in_frame) |-> $past(mem_ack, 4))
		else begin
			fail_count++;
			$error("frame ended without a completed burst");
		end

endmodule

/* test/tb_video_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the BT.656 capture path
// Drives BT.656 lines, models the memory bus and checks every burst
// against RGB565 pairs computed here from the conversion rule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_video_capture import vidcap_pkg::*; ;

	localparam int planned_bytes = 60 + 324 + 96 + 204 + 102 + 112; // Per test, in order
	localparam int watchdog_cycles = planned_bytes * 40 + 2000;

	logic                   sys_clk;
	logic                   sys_rst;
	logic [7:0]             vid_data;
	logic                   vid_stb;
	logic [1:0]             field_filter;
	logic [burst_adr_w-1:0] adr_base;
	logic [15:0]            frame_bursts;
	mem_req_t               mem;
	logic                   mem_ack;
	logic                   in_frame;
	logic                   start_of_frame;
	logic                   overflow;

	logic [15:0]          lfsr;
	logic                 slow_ack;  // Memory model stalls its ack
	int                   sof_count;
	logic [31:0]          exp_q[$];  // Expected pixel words in send order
	logic [mem_depth-1:0] got_adr[$];
	logic [63:0]          got_dat[$]; // Four beats per burst

	video_capture_top DUT (.*);

	bind capture_dma video_capture_assertions u_assert (
		.sys_clk        (sys_clk),
		.sys_rst        (sys_rst),
		.mem            (mem),
		.mem_ack        (mem_ack),
		.in_frame       (in_frame),
		.start_of_frame (start_of_frame)
	);

	always #10 sys_clk = ~sys_clk;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = 8'd0;
		for (int i = 0; i < n; i++)
			r = {r[6:0], lfsr_step()};
		return r;
	endfunction

	function automatic logic [7:0] clip255(input int v);
		logic [7:0] c;
		c = (v < 0) ? 8'd0 : (v > 255) ? 8'hff : 8'(v);
		return c;
	endfunction

	function automatic logic [15:0] rgb565_of(input int y, input int d, input int e);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		r = clip255(y + ((359 * e) >>> 8));
		g = clip255(y - ((88 * d + 183 * e) >>> 8));
		b = clip255(y + ((454 * d) >>> 8));
		return {r[7:3], g[7:2], b[7:3]};
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic drive_byte(input logic [7:0] b);
		@(posedge sys_clk);
		#1;
		vid_data = b;
		vid_stb  = 1'b1;
		@(posedge sys_clk);
		#1;
		vid_stb = 1'b0; // One idle cycle between bytes
	endtask

	task automatic send_code(input logic f, input logic v, input logic h);
		drive_byte(8'hff);
		drive_byte(8'h00);
		drive_byte(8'h00);
		drive_byte({1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h});
	endtask

	// Random payload never contains FF
	task automatic send_random(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = rand_bits(8);
			drive_byte((b == 8'hff) ? 8'hfe : b);
		end
	endtask

	// SAV, nq quads, extra stray bytes, EAV, horizontal blanking
	task automatic send_line(input logic f, input logic v, input int nq, input int extra);
		logic [7:0] s[4];
		send_code(f, v, 1'b0);
		for (int q = 0; q < nq; q++) begin
			for (int i = 0; i < 4; i++) begin
				s[i] = rand_bits(8);
				if (s[i] == 8'hff)
					s[i] = 8'hfe;
				drive_byte(s[i]);
			end
			if (!v)
				exp_q.push_back({rgb565_of(int'(s[3]), int'(s[0]) - 128, int'(s[2]) - 128),
					rgb565_of(int'(s[1]), int'(s[0]) - 128, int'(s[2]) - 128)});
		end
		send_random(extra);
		send_code(f, v, 1'b1);
		send_random(4);
	endtask

	task automatic apply_reset();
		@(posedge sys_clk);
		#1;
		sys_rst = 1'b1;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		exp_q.delete();
		got_adr.delete();
		got_dat.delete();
	endtask

	task automatic wait_bursts(input int n);
		int cyc;
		cyc = 0;
		while (got_adr.size() < n) begin
			@(posedge sys_clk);
			cyc++;
			if (cyc > 2000) begin
				$display("Memory burst %0d never completed on the bus", n);
				$display("TEST FAILED");
				$fatal(1, "burst timeout");
			end
		end
		@(negedge sys_clk);
	endtask

	// Bursts from index first, data from exp_q starting at word s
	task automatic check_bursts(input int first, input int nb, input int s,
		input logic [burst_adr_w-1:0] base);
		for (int k = 0; k < nb; k++) begin
			compare("mem.adr", 64'({base + burst_adr_w'(k), 5'd0}), 64'(got_adr[first + k]));
			for (int b = 0; b < 4; b++)
				compare("mem.dat", {exp_q[s + 8 * k + 2 * b + 1], exp_q[s + 8 * k + 2 * b]},
					got_dat[4 * (first + k) + b]);
		end
	endtask

	task automatic setup(input logic [1:0] ff, input int nb, input logic [burst_adr_w-1:0] base);
		apply_reset();
		field_filter = ff;
		frame_bursts = 16'(nb);
		adr_base     = base;
	endtask

	task automatic test_reset_state();
		setup(2'b01, 1, '0);
		@(negedge sys_clk);
		compare("mem.stb", 64'(1'b0), 64'(mem.stb));
		compare("in_frame", 64'(1'b0), 64'(in_frame));
		compare("start_of_frame", 64'(1'b0), 64'(start_of_frame));
		compare("overflow", 64'(1'b0), 64'(overflow));
		send_line(1'b0, 1'b1, 2, 0);
		send_line(1'b1, 1'b1, 2, 0);
		send_line(1'b0, 1'b1, 2, 0);
		@(negedge sys_clk);
		compare("bursts", 64'(0), 64'(got_adr.size()));
		compare("in_frame", 64'(1'b0), 64'(in_frame));
	endtask

	// Fields f0, f1, f0; a frame starts on the third line if allowed
	task automatic filter_case(input logic [1:0] ff, input logic f0, input logic expect_sof);
		setup(ff, 1, 22'h00100);
		send_line(f0, 1'b0, 2, 0);
		send_line(~f0, 1'b0, 8, 0);
		compare("bursts", 64'(0), 64'(got_adr.size()));
		send_line(f0, 1'b0, 8, 0);
		if (expect_sof) begin
			wait_bursts(1);
			check_bursts(0, 1, 10, 22'h00100);
		end
		@(negedge sys_clk);
		compare("sof_count", 64'(expect_sof), 64'(sof_count));
		compare("bursts", 64'(expect_sof), 64'(got_adr.size()));
	endtask

	task automatic test_field_filter();
		filter_case(2'b01, 1'b0, 1'b1);
		filter_case(2'b10, 1'b1, 1'b1);
		filter_case(2'b00, 1'b0, 1'b0);
	endtask

	task automatic test_conversion();
		setup(2'b01, 2, 22'h0abcd);
		send_line(1'b1, 1'b0, 2, 0);
		send_line(1'b0, 1'b0, 16, 0);
		wait_bursts(2);
		check_bursts(0, 2, 2, 22'h0abcd);
	endtask

	task automatic test_addressing();
		setup(2'b01, 3, 22'h12345);
		send_line(1'b1, 1'b0, 1, 0);
		send_line(1'b0, 1'b0, 28, 0);
		wait_bursts(3);
		check_bursts(0, 3, 1, 22'h12345);
		compare("in_frame", 64'(1'b0), 64'(in_frame));
		send_line(1'b1, 1'b0, 2, 0);
		send_line(1'b0, 1'b0, 8, 0); // Next 1 to 0 field restarts at base
		wait_bursts(4);
		check_bursts(3, 1, 31, 22'h12345);
	endtask

	task automatic test_blanking();
		setup(2'b01, 1, 22'h00040);
		send_line(1'b1, 1'b0, 1, 0);
		send_line(1'b0, 1'b1, 4, 0); // Vertical blanking with video-like bytes
		send_line(1'b0, 1'b0, 4, 2); // Stray tail bytes must not shift the next line
		send_line(1'b0, 1'b0, 4, 0);
		wait_bursts(1);
		check_bursts(0, 1, 1, 22'h00040);
	endtask

	task automatic test_overflow();
		setup(2'b01, 1, 22'h00200);
		slow_ack = 1'b1;
		send_line(1'b1, 1'b0, 1, 0);
		send_line(1'b0, 1'b0, 16, 0);
		wait_bursts(1);
		slow_ack = 1'b0;
		check_bursts(0, 1, 1, 22'h00200);
		compare("overflow", 64'(1'b1), 64'(overflow));
		send_line(1'b1, 1'b1, 2, 0);
		@(negedge sys_clk);
		compare("overflow", 64'(1'b1), 64'(overflow)); // Sticky
		apply_reset();
		@(negedge sys_clk);
		compare("overflow", 64'(1'b0), 64'(overflow));
	endtask

	always @(negedge sys_clk) begin
		if (sys_rst)
			sof_count <= 0;
		else if (start_of_frame)
			sof_count <= sof_count + 1;
	end

	// Memory model, ack after 0 to 3 cycles, beats sampled mid-cycle
	initial begin
		int                   dly;
		logic [mem_depth-1:0] adr;
		logic [63:0]          beats[4];
		mem_ack = 1'b0;
		forever begin
			@(posedge sys_clk);
			#1;
			if (mem.stb && !sys_rst) begin
				dly = slow_ack ? 40 : int'(rand_bits(2));
				repeat (dly) begin
					@(posedge sys_clk);
					#1;
				end
				adr     = mem.adr; // Held with the strobe until ack
				mem_ack = 1'b1;
				for (int b = 0; b < 4; b++) begin
					@(negedge sys_clk);
					beats[b] = mem.dat;
					@(posedge sys_clk);
					#1;
					mem_ack = 1'b0;
				end
				got_adr.push_back(adr);
				for (int b = 0; b < 4; b++)
					got_dat.push_back(beats[b]);
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("Run timed out after %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$fatal(1, "watchdog");
	end

	initial begin
		sys_clk      = 1'b0;
		sys_rst      = 1'b1;
		vid_data     = 8'd0;
		vid_stb      = 1'b0;
		field_filter = 2'b00;
		adr_base     = '0;
		frame_bursts = 16'd0;
		lfsr         = 16'd77;
		slow_ack     = 1'b0;
		test_reset_state();
		test_field_filter();
		test_conversion();
		test_addressing();
		test_blanking();
		test_overflow();
		if (DUT.u_dma.u_assert.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* filelist.f */
hdl/vidcap_pkg.sv
hdl/bt656_sync_decoder.sv
hdl/ycbcr_to_rgb565.sv
hdl/burst_buffer.sv
hdl/capture_dma.sv
hdl/video_capture_top.sv
test/video_capture_assertions.sv
test/tb_video_capture.sv

/* Makefile */
# Verilator build for the BT.656 capture testbench

VERILATOR  ?= verilator
TOP        := tb_video_capture
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
